// File: design/apu_pkg.sv
package apu_pkg;

	localparam int data_w = 8;             // everything in the core is byte wide

	// internal timer ports, never seen outside
	localparam logic [3:0] port_tmr_lo = 4'd2;   // low byte, latched only
	localparam logic [3:0] port_tmr_hi = 4'd3;   // high byte, loads the counter

	// opcode in instr[15:12]
	// immediate ops 0..6 line up with fn_ld..fn_cmp
	typedef enum logic [3:0] {
		op_ld_i  = 4'h0,
		op_and_i = 4'h1,
		op_or_i  = 4'h2,
		op_xor_i = 4'h3,
		op_add_i = 4'h4,
		op_sub_i = 4'h5,
		op_cmp_i = 4'h6,
		op_alu_r = 4'h7,      // dst op src, fn in instr[6:4]
		op_unary = 4'h8,      // dst = fn(src)
		op_jr    = 4'h9,
		op_wait  = 4'ha,
		op_out   = 4'hb,
		op_pin   = 4'hc,
		op_rsv_d = 4'hd,      // spare, runs as nop
		op_rsv_e = 4'he,      // spare, runs as nop
		op_halt  = 4'hf
	} apu_op_e;

	// alu function, msb set for the unary group
	typedef enum logic [3:0] {
		fn_ld   = 4'h0,
		fn_and  = 4'h1,
		fn_or   = 4'h2,
		fn_xor  = 4'h3,
		fn_add  = 4'h4,
		fn_sub  = 4'h5,
		fn_cmp  = 4'h6,
		fn_inc  = 4'h8,
		fn_dec  = 4'h9,
		fn_cpl  = 4'ha,
		fn_neg  = 4'hb,
		fn_swap = 4'hc,
		fn_flip = 4'hd
	} alu_fn_e;

	typedef enum logic [2:0] {
		jc_always, jc_z, jc_c, jc_nz, jc_nc, jc_n, jc_nn, jc_never
	} jcond_e;

	typedef enum logic [1:0] {
		st_idle,        // held by apu_halt
		st_fetch,
		st_exec,
		st_stop         // after op_halt
	} core_state_e;

	typedef struct packed {
		logic z;
		logic c;
		logic n;
	} flags_t;

	typedef struct packed {
		logic [3:0]        port;
		logic [data_w-1:0] data;
	} port_wr_t;

endpackage

// File: design/apu_code_ram.sv
`timescale 1ns/1ps

module apu_code_ram #(
	parameter int code_depth = 256,
	localparam int pc_w = $clog2(code_depth)
) (
	input  logic            clk,
	input  logic            code_wen,
	input  logic [8:0]      code_waddr,   // byte address from host
	input  logic [7:0]      code_wdata,
	input  logic [pc_w-1:0] rd_addr,
	output logic [15:0]     instr
);

	logic [7:0]  lo_byte;                  // low half waiting for its odd partner
	logic [15:0] mem [code_depth];

	// even byte goes to the holding register only
	always_ff @(posedge clk)
	begin
		if (code_wen && !code_waddr[0])
			lo_byte <= code_wdata;
	end

	// odd byte completes the word, read port is registered
	always_ff @(posedge clk)
	begin
		if (code_wen && code_waddr[0])
			mem[code_waddr[pc_w:1]] <= {code_wdata, lo_byte};   // hi byte on top
		instr <= mem[rd_addr];
	end

endmodule

// File: design/apu_timer.sv
`timescale 1ns/1ps

module apu_timer import apu_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     wr_valid,   // already restricted to timer ports
	input  port_wr_t wr,
	output logic     cnt_end
);

	logic [7:0]  lo_byte;        // staged low half
	logic [15:0] cnt;

	always_ff @(posedge clk)
	begin
		if (wr_valid && wr.port == port_tmr_lo)
			lo_byte <= wr.data;
	end

	// load on high byte, then count to zero and park there
	always_ff @(posedge clk)
	begin
		if (reset)
			cnt <= '0;
		else if (wr_valid && wr.port == port_tmr_hi)
			cnt <= {wr.data, lo_byte};
		else if (cnt != '0)
			cnt <= cnt - 1'b1;   // one tick per clk
	end

	assign cnt_end = (cnt == '0);   // also high straight out of reset

endmodule

// File: design/apu_alu.sv
`timescale 1ns/1ps

module apu_alu import apu_pkg::*; (
	input  alu_fn_e           fn,
	input  logic [data_w-1:0] a,          // destination register
	input  logic [data_w-1:0] b,          // immediate or source register
	input  flags_t            flags_in,
	output logic [data_w-1:0] res,
	output flags_t            flags_out,
	output logic              wr_en       // low means leave dst alone
);

	logic [data_w:0] wide;                // extra bit is carry or borrow
	logic            c;
	logic            keep;                // undefined fn, flags untouched

	always_comb
	begin
		wide  = '0;
		res   = b;
		c     = flags_in.c;               // logic ops keep carry
		wr_en = 1'b1;
		keep  = 1'b0;
		case (fn)
			fn_ld:   res = b;
			fn_and:  res = a & b;
			fn_or:   res = a | b;
			fn_xor:  res = a ^ b;
			fn_add, fn_inc:
			begin
				wide = (fn == fn_inc) ? {1'b0, b} + 1'b1 : {1'b0, a} + {1'b0, b};
				res  = wide[data_w-1:0];
				c    = wide[data_w];          // carry out
			end
			fn_sub, fn_cmp:
			begin
				wide  = {1'b0, a} - {1'b0, b};
				res   = wide[data_w-1:0];
				c     = wide[data_w];         // borrow, a < b
				wr_en = (fn != fn_cmp);       // cmp only sets flags
			end
			fn_dec:
			begin
				wide = {1'b0, b} - 1'b1;
				res  = wide[data_w-1:0];
				c    = wide[data_w];          // borrow on 0
			end
			fn_cpl:  res = ~b;
			fn_neg:
			begin
				wide = '0 - {1'b0, b};
				res  = wide[data_w-1:0];
				c    = wide[data_w];          // set unless b is 0
			end
			fn_swap: res = {b[3:0], b[7:4]};    // nibble swap
			fn_flip: res = {<<{b}};              // bit reverse
			default:
			begin
				res   = a;
				wr_en = 1'b0;
				keep  = 1'b1;
			end
		endcase
		flags_out.z = (res == '0);
		flags_out.c = c;
		flags_out.n = res[data_w-1];
		if (keep)
			flags_out = flags_in;
	end

endmodule

// File: design/apu_core.sv
`timescale 1ns/1ps

module apu_core import apu_pkg::*; #(
	parameter int code_depth = 256,
	parameter int credits = 4,
	localparam int pc_w = $clog2(code_depth),
	localparam int cnt_w = $clog2(credits + 1)
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            apu_halt,
	input  logic [15:0]     instr,
	input  logic [7:0]      pins_in,      // pin 0 const one, pin 1 timer end
	input  logic            credit_ret,
	output logic [pc_w-1:0] rd_addr,
	output logic            port_wr_valid,
	output port_wr_t        port_wr,
	output logic [7:0]      pins_out,
	output logic            apu_rdy
);

	core_state_e       state;
	logic [pc_w-1:0]   pc;
	logic [pc_w-1:0]   pc_next;
	logic [cnt_w-1:0]  credit_cnt;
	logic [data_w-1:0] rf [16];          // general registers
	flags_t            flags;
	flags_t            alu_flags;
	apu_op_e           op;
	alu_fn_e           fn;
	logic [3:0]        dst;
	logic [3:0]        src;
	logic [data_w-1:0] alu_b;
	logic [data_w-1:0] alu_res;
	logic              alu_wr;
	logic              alu_op;           // op writes result and flags
	logic              taken;
	logic              pin_val;
	logic              done;             // exec cycle finishes this instr
	logic              exec;
	logic              send;

	assign op      = apu_op_e'(instr[15:12]);
	assign dst     = instr[11:8];
	assign src     = instr[3:0];
	assign pin_val = pins_in[instr[2:0]];
	assign rd_addr = pc;                 // ram returns the word next cycle
	assign exec    = (state == st_exec) && !apu_halt;

	// operand and function select
	always_comb
	begin
		alu_op = 1'b0;
		alu_b  = instr[7:0];              // immediate by default
		fn     = alu_fn_e'({1'b0, instr[14:12]});
		case (op)
			op_ld_i, op_and_i, op_or_i, op_xor_i, op_add_i, op_sub_i, op_cmp_i:
				alu_op = 1'b1;
			op_alu_r:
			begin
				alu_op = 1'b1;
				alu_b  = rf[src];
				fn     = alu_fn_e'({1'b0, instr[6:4]});
			end
			op_unary:
			begin
				alu_op = 1'b1;
				alu_b  = rf[src];
				fn     = alu_fn_e'({1'b1, instr[6:4]});
			end
			default: alu_op = 1'b0;
		endcase
	end

	apu_alu u_alu (
		.fn        (fn),
		.a         (rf[dst]),
		.b         (alu_b),
		.flags_in  (flags),
		.res       (alu_res),
		.flags_out (alu_flags),
		.wr_en     (alu_wr)
	);

	always_comb
	begin
		case (jcond_e'(instr[10:8]))
			jc_always: taken = 1'b1;
			jc_z:      taken = flags.z;
			jc_c:      taken = flags.c;
			jc_nz:     taken = !flags.z;
			jc_nc:     taken = !flags.c;
			jc_n:      taken = flags.n;
			jc_nn:     taken = !flags.n;
			default:   taken = 1'b0;     // jc_never
		endcase
	end

	// stall conditions, exec repeats until done
	always_comb
	begin
		case (op)
			op_wait: done = (pin_val == instr[7]);
			op_out:  done = (credit_cnt != '0);
			default: done = 1'b1;
		endcase
	end

	assign send = exec && (op == op_out) && done;

	// offset is relative to the jr word itself
	assign pc_next = (op == op_jr && taken) ? pc + pc_w'(signed'(instr[7:0])) : pc + 1'b1;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state         <= st_idle;
			pc            <= '0;
			flags         <= '0;
			pins_out      <= '0;
			port_wr_valid <= 1'b0;
			apu_rdy       <= 1'b0;
			credit_cnt    <= cnt_w'(credits);
			for (int i = 0; i < 16; i++)
				rf[i] <= '0;
		end
		else
		begin
			port_wr_valid <= send;
			apu_rdy       <= (state == st_stop) && !apu_halt;   // one edge after st_stop
			credit_cnt    <= credit_cnt + cnt_w'(credit_ret) - cnt_w'(send);
			if (apu_halt)
			begin
				state <= st_idle;             // host owns the core
				pc    <= '0;
			end
			else
			begin
				case (state)
					st_idle:  state <= st_fetch;
					st_fetch: state <= st_exec;   // instr valid next cycle
					st_exec:
					if (done)
					begin
						pc    <= pc_next;
						state <= (op == op_halt) ? st_stop : st_fetch;
						if (alu_op)
						begin
							flags <= alu_flags;
							if (alu_wr)
								rf[dst] <= alu_res;
						end
						if (op == op_pin)
							pins_out[instr[2:0]] <= instr[7];   // polarity bit
					end
					default: state <= st_stop;    // stays until apu_halt
				endcase
			end
		end
	end

	// payload, qualified by port_wr_valid
	always_ff @(posedge clk)
	begin
		if (send)
			port_wr <= '{port: instr[7:4], data: rf[dst]};
	end

endmodule

// File: design/apu_top.sv
`timescale 1ns/1ps

module apu_top import apu_pkg::*; #(
	parameter int code_depth = 256,
	parameter int credits = 4,
	localparam int pc_w = $clog2(code_depth),
	localparam int pend_w = $clog2(credits + 1)
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       apu_halt,
	input  logic       code_wen,
	input  logic [8:0] code_waddr,
	input  logic [7:0] code_wdata,
	input  logic [5:0] pins_in,
	input  logic       credit_ret,
	output logic       port_wr_valid,
	output port_wr_t   port_wr,
	output logic [7:0] pins_out,
	output logic       apu_rdy
);

	logic [pc_w-1:0]   rd_addr;
	logic [15:0]       instr;
	logic              timer_end;
	logic              core_valid;
	port_wr_t          core_wr;
	logic              tmr_sel;       // write aimed at the timer
	logic              tmr_ret;
	logic              core_ret;
	logic [pend_w-1:0] ret_pend;      // returns that lost a collision

	assign tmr_sel       = (core_wr.port == port_tmr_lo) || (core_wr.port == port_tmr_hi);
	assign tmr_ret       = core_valid && tmr_sel;
	assign port_wr_valid = core_valid && !tmr_sel;
	assign port_wr       = core_wr;

	// timer credit comes back at once, a clash with the sink is held over
	assign core_ret = credit_ret || tmr_ret || (ret_pend != '0);

	always_ff @(posedge clk)
	begin
		if (reset)
			ret_pend <= '0;
		else if (credit_ret && tmr_ret)
			ret_pend <= ret_pend + 1'b1;
		else if (!credit_ret && !tmr_ret && ret_pend != '0)
			ret_pend <= ret_pend - 1'b1;
	end

	apu_code_ram #(.code_depth(code_depth)) u_code_ram (
		.clk        (clk),
		.code_wen   (code_wen),
		.code_waddr (code_waddr),
		.code_wdata (code_wdata),
		.rd_addr    (rd_addr),
		.instr      (instr)
	);

	apu_core #(.code_depth(code_depth), .credits(credits)) u_core (
		.clk           (clk),
		.reset         (reset),
		.apu_halt      (apu_halt),
		.instr         (instr),
		.pins_in       ({pins_in, timer_end, 1'b1}),   // pin 0 always one
		.credit_ret    (core_ret),
		.rd_addr       (rd_addr),
		.port_wr_valid (core_valid),
		.port_wr       (core_wr),
		.pins_out      (pins_out),
		.apu_rdy       (apu_rdy)
	);

	apu_timer u_timer (
		.clk      (clk),
		.reset    (reset),
		.wr_valid (tmr_ret),
		.wr       (core_wr),
		.cnt_end  (timer_end)
	);

endmodule

// File: tb/apu_clock_gen.sv
`timescale 1ns/1ps

module apu_clock_gen #(
	parameter int period = 8                // ns
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(period / 2.0) clk = ~clk;   // free running, 50 % duty
	end

endmodule

// File: tb/apu_tb.sv
`timescale 1ns/1ps

module apu_tb import apu_pkg::*; ();

	localparam int credits = 4;
	localparam int t_load  = 40;            // timer start value, cycles

	logic        clk;
	logic        reset = 1'b1;
	logic        apu_halt = 1'b1;
	logic        code_wen = 1'b0;
	logic [8:0]  code_waddr = '0;
	logic [7:0]  code_wdata = '0;
	logic [5:0]  pins_in = '0;
	logic        credit_ret = 1'b0;
	logic        port_wr_valid;
	port_wr_t    port_wr;
	logic [7:0]  pins_out;
	logic        apu_rdy;
	logic [15:0] prog [$];                  // program words
	port_wr_t    exp_q [$];                 // predicted external writes, oldest first
	int          ret_due [$];               // cycle each pending credit goes back
	int          wr_cyc [$];                // cycle stamps of external writes
	logic [7:0]  exp_pins = '0;             // survives reruns like pins_out
	logic [31:0] seed = 32'hea93b11b;
	logic        halt_d = 1'b1;
	int          errors = 0;
	int          cyc = 0;
	int          outstanding = 0;
	int          hold_until = 0;            // sink holds credits until this cycle

	apu_clock_gen #(.period(8)) u_clk (.clk(clk));

	apu_top #(.code_depth(256), .credits(credits)) uut (
		.clk(clk), .reset(reset), .apu_halt(apu_halt), .code_wen(code_wen),
		.code_waddr(code_waddr), .code_wdata(code_wdata), .pins_in(pins_in),
		.credit_ret(credit_ret), .port_wr_valid(port_wr_valid), .port_wr(port_wr),
		.pins_out(pins_out), .apu_rdy(apu_rdy)
	);

	function automatic logic [7:0] rand8();
		seed = seed * 32'd1664525 + 32'd1013904223;   // lcg step
		return seed[23:16];
	endfunction

	function automatic logic [15:0] ins(apu_op_e op, logic [3:0] r, logic [7:0] k);
		return {op, r, k};
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;                                 // inputs change just after the edge
	endtask

	task automatic end_run();
		$display("summary: %0d errors, %0d writes unmatched", errors, exp_q.size());
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	// instruction level model of the program
	task automatic model_run();
		logic [7:0]  r [16];
		logic [15:0] w;
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  res;
		logic        c;
		logic        alu;
		logic        jump;
		flags_t      f;
		alu_fn_e     fn;
		apu_op_e     op;
		int          pc;
		int          steps;
		exp_q.delete();
		f = '0;
		pc = 0;
		steps = 0;
		foreach (r[i])
			r[i] = '0;
		while (pc < prog.size() && prog[pc][15:12] != op_halt && steps < 4000)
		begin
			w    = prog[pc];
			op   = apu_op_e'(w[15:12]);
			a    = r[w[11:8]];
			b    = (op == op_alu_r || op == op_unary) ? r[w[3:0]] : w[7:0];
			alu  = 1'b1;
			jump = 1'b0;
			fn   = alu_fn_e'({1'b0, w[14:12]});    // immediates map straight
			case (op)
				op_alu_r: fn = alu_fn_e'({1'b0, w[6:4]});
				op_unary: fn = alu_fn_e'({1'b1, w[6:4]});
				op_jr, op_wait, op_out, op_pin, op_rsv_d, op_rsv_e, op_halt: alu = 1'b0;
				default: alu = 1'b1;
			endcase
			c   = f.c;                         // logic ops keep carry
			res = b;
			case (fn)
				fn_and:  res = a & b;
				fn_or:   res = a | b;
				fn_xor:  res = a ^ b;
				fn_add:  {c, res} = {1'b0, a} + {1'b0, b};
				fn_sub, fn_cmp: {c, res} = {1'b0, a} - {1'b0, b};   // c is borrow
				fn_inc:  {c, res} = {1'b0, b} + 9'd1;
				fn_dec:  {c, res} = {1'b0, b} - 9'd1;
				fn_cpl:  res = ~b;
				fn_neg:  {c, res} = 9'd0 - {1'b0, b};
				fn_swap: res = {b[3:0], b[7:4]};
				fn_flip: for (int i = 0; i < 8; i++) res[i] = b[7 - i];
				default: res = b;                  // ld
			endcase
			if (alu)
			begin
				f.z = (res == 8'h00);
				f.c = c;
				f.n = res[7];
				if (fn != fn_cmp)
					r[w[11:8]] = res;
			end
			if (op == op_jr)
				case (jcond_e'(w[10:8]))
					jc_always: jump = 1'b1;
					jc_z:      jump = f.z;
					jc_c:      jump = f.c;
					jc_nz:     jump = !f.z;
					jc_nc:     jump = !f.c;
					jc_n:      jump = f.n;
					jc_nn:     jump = !f.n;
					default:   jump = 1'b0;
				endcase
			if (op == op_pin)
				exp_pins[w[2:0]] = w[7];
			if (op == op_out && w[7:4] != port_tmr_lo && w[7:4] != port_tmr_hi)
				exp_q.push_back(port_wr_t'({w[7:4], a}));   // timer ports stay inside
			pc = jump ? pc + $signed(w[7:0]) : pc + 1;   // offset from the jr word
			steps++;
		end
		if (steps >= 4000)
		begin
			errors++;
			$display("model never reached op_halt");
		end
	endtask

	task automatic load_prog();
		foreach (prog[i])
			for (int h = 0; h < 2; h++)
			begin
				tick();
				code_wen   = 1'b1;
				code_waddr = 9'(2 * i + h);    // low byte first
				code_wdata = prog[i][8 * h +: 8];
			end
		tick();
		code_wen = 1'b0;
	endtask

	task automatic start_prog();
		model_run();
		tick();
		apu_halt = 1'b0;
	endtask

	task automatic finish_prog();
		int t;
		t = 0;
		while (!apu_rdy && t < 4000)
		begin
			tick();
			t++;
		end
		if (!apu_rdy)
		begin
			errors++;
			$display("apu_rdy never rose within %0d cycles", t);
			end_run();
		end
		repeat (8) tick();                   // nothing may follow the halt
		assert (exp_q.size() == 0)
		else
		begin
			errors++;
			$display("%0d predicted writes never appeared", exp_q.size());
		end
		assert (pins_out == exp_pins)
		else
		begin
			errors++;
			$display("[FAIL] %0t pins_out exp %h got %h", $time, exp_pins, pins_out);
		end
		apu_halt = 1'b1;
		repeat (2) tick();
	endtask

	task automatic timer_gap_check();
		assert (wr_cyc.size() == 2 && wr_cyc[1] - wr_cyc[0] >= t_load)
		else
		begin
			errors++;
			$display("[FAIL] %0t port_wr gap exp >= %0d got %0d", $time, t_load,
				(wr_cyc.size() == 2) ? wr_cyc[1] - wr_cyc[0] : -1);
		end
	endtask

	// sink side, each credit comes back after a random delay
	always @(posedge clk)
	begin
		if (port_wr_valid && !reset)
			ret_due.push_back(cyc + 1 + int'(rand8() % 8'd6));
		#1;
		cyc++;
		credit_ret = (cyc >= hold_until) && ret_due.size() > 0 && ret_due[0] <= cyc;
		if (credit_ret)
			void'(ret_due.pop_front());
	end

	// response checks on every edge
	always @(posedge clk)
	begin
		if (!reset)
		begin
			assert (!port_wr_valid || exp_q.size() > 0)
			else
			begin
				errors++;
				$display("%0t write to port %0d with none expected", $time, port_wr.port);
			end
			if (port_wr_valid && exp_q.size() > 0)
			begin
				assert (port_wr == exp_q[0])
				else
				begin
					errors++;
					$display("[FAIL] %0t port_wr exp %h got %h", $time, exp_q[0], port_wr);
				end
				void'(exp_q.pop_front());
				wr_cyc.push_back(cyc);
			end
			outstanding += int'(port_wr_valid) - int'(credit_ret);
			assert (outstanding <= credits)
			else
			begin
				errors++;
				$display("%0t %0d writes outstanding on %0d credits", $time, outstanding, credits);
			end
			assert (!(apu_rdy && port_wr_valid))
			else
			begin
				errors++;
				$display("%0t port write seen after apu_rdy", $time);
			end
			assert (!(halt_d && apu_rdy))
			else
			begin
				errors++;
				$display("[FAIL] %0t apu_rdy exp 0 got %b", $time, apu_rdy);
			end
		end
		halt_d = apu_halt;
	end

	initial
	begin
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// every alu function on random operands
		for (int k = 0; k <= 6; k++)
		begin
			prog.push_back(ins(op_ld_i, 4'd1, rand8()));
			prog.push_back(ins(apu_op_e'(k), 4'd1, rand8()));
			prog.push_back(ins(op_out, 4'd1, 8'h60));
			prog.push_back(ins(op_ld_i, 4'd1, rand8()));
			prog.push_back(ins(op_ld_i, 4'd2, rand8()));
			prog.push_back(ins(op_alu_r, 4'd1, {1'b0, 3'(k), 4'd2}));
			prog.push_back(ins(op_out, 4'd1, 8'h70));
		end
		for (int k = 0; k <= 5; k++)
		begin
			prog.push_back(ins(op_ld_i, 4'd1, rand8()));
			prog.push_back(ins(op_ld_i, 4'd2, rand8()));
			prog.push_back(ins(op_unary, 4'd1, {1'b0, 3'(k), 4'd2}));
			prog.push_back(ins(op_out, 4'd1, 8'h80));
		end
		prog.push_back(ins(op_halt, 4'd0, 8'h00));
		load_prog();
		start_prog();
		finish_prog();

		// countdown loop, then cmp against each jump condition
		prog.delete();
		prog.push_back(ins(op_ld_i, 4'd1, 8'd5));
		prog.push_back(ins(op_out, 4'd1, 8'h40));
		prog.push_back(ins(op_unary, 4'd1, 8'h11));   // dec r1
		prog.push_back(ins(op_jr, 4'd3, 8'hfe));      // nz, back to the out
		for (int j = 0; j < 3; j++)
		begin
			prog.push_back(ins(op_ld_i, 4'd2, 8'h40));
			prog.push_back(ins(op_cmp_i, 4'd2, (j == 0) ? 8'h40 : ((j == 1) ? 8'h50 : 8'h10)));
			for (int cnd = 0; cnd < 8; cnd++)
			begin
				prog.push_back(ins(op_jr, 4'(cnd), 8'd2));   // taken skips the out
				prog.push_back(ins(op_out, 4'd2, {1'b1, 3'(cnd), 4'h0}));
			end
		end
		prog.push_back(ins(op_halt, 4'd0, 8'h00));
		load_prog();
		start_prog();
		finish_prog();

		// credits held back for a while
		prog.delete();
		for (int k = 0; k < 12; k++)
		begin
			prog.push_back(ins(op_ld_i, 4'd3, rand8()));
			prog.push_back(ins(op_out, 4'd3, 8'h50));
		end
		prog.push_back(ins(op_halt, 4'd0, 8'h00));
		load_prog();
		hold_until = cyc + 100;
		start_prog();
		repeat (50) tick();
		assert (exp_q.size() == 12 - credits)
		else
		begin
			errors++;
			$display("%0d writes passed while credits were held", 12 - exp_q.size());
		end
		finish_prog();

		// output pins, and a write gated by pin 4 (pins_in[2])
		prog.delete();
		prog.push_back(ins(op_pin, 4'd0, 8'h85));
		prog.push_back(ins(op_pin, 4'd0, 8'h80));
		prog.push_back(ins(op_pin, 4'd0, 8'h86));
		prog.push_back(ins(op_pin, 4'd0, 8'h05));
		prog.push_back(ins(op_ld_i, 4'd4, 8'ha5));
		prog.push_back(ins(op_out, 4'd4, 8'h90));
		prog.push_back(ins(op_wait, 4'd0, 8'h84));
		prog.push_back(ins(op_out, 4'd4, 8'ha0));
		prog.push_back(ins(op_halt, 4'd0, 8'h00));
		load_prog();
		start_prog();
		repeat (60) tick();
		assert (exp_q.size() == 1)
		else
		begin
			errors++;
			$display("write after the pin wait came before pin 4 was raised");
		end
		pins_in[2] = 1'b1;
		finish_prog();
		pins_in = '0;

		// timer load, wait on pin 1, then the same program again after a halt
		prog.delete();
		prog.push_back(ins(op_ld_i, 4'd1, 8'(t_load)));
		prog.push_back(ins(op_ld_i, 4'd2, 8'h00));
		prog.push_back(ins(op_ld_i, 4'd3, 8'h3c));
		prog.push_back(ins(op_out, 4'd3, 8'h50));
		prog.push_back(ins(op_out, 4'd1, {port_tmr_lo, 4'h0}));
		prog.push_back(ins(op_out, 4'd2, {port_tmr_hi, 4'h0}));   // starts the count
		prog.push_back(ins(op_wait, 4'd0, 8'h81));
		prog.push_back(ins(op_out, 4'd3, 8'h50));
		prog.push_back(ins(op_halt, 4'd0, 8'h00));
		load_prog();
		for (int run = 0; run < 2; run++)
		begin
			wr_cyc.delete();
			start_prog();
			finish_prog();
			timer_gap_check();
		end
		end_run();
	end

endmodule

// File: build.f
design/apu_pkg.sv
design/apu_code_ram.sv
design/apu_timer.sv
design/apu_alu.sv
design/apu_core.sv
design/apu_top.sv
tb/apu_clock_gen.sv
tb/apu_tb.sv
